// File: hdl/hbm_host_defs.svh
// host memory path constants
// widths of the host request bus, debounce length and LED timing

`ifndef HBM_HOST_DEFS_SVH
`define HBM_HOST_DEFS_SVH

// --------------------------------------------------
// request bus widths
// --------------------------------------------------
`define HBM_ADDR_WIDTH 8    // word address, 256 words
`define HBM_DATA_WIDTH 32   // data word

// --------------------------------------------------
// board housekeeping
// --------------------------------------------------
`define HBM_DBNC_CYCLES 16  // stable edges before the button is believed

// cycles an activity LED stays lit after its last request
`define HBM_LED_HOLD 32

`define HBM_LED_WIDTH 3     // reset, write, read

`endif

// File: hdl/hbm_host_pkg.sv
// host memory path types
// data types and enums shared by the request slice, the memory and
// the LED monitor

`default_nettype none

`include "hbm_host_defs.svh"

package hbm_host_pkg;

  typedef logic [`HBM_ADDR_WIDTH-1:0] addr_t;  // word address
  typedef logic [`HBM_DATA_WIDTH-1:0] data_t;  // data word

  // bit 0 reset, bit 1 write activity, bit 2 read activity
  typedef logic [`HBM_LED_WIDTH-1:0] led_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } host_op_e;

  // activity LED hold machine
  typedef enum logic {
    LED_IDLE = 1'b0,  // LED dark
    LED_HOLD = 1'b1   // LED lit, hold counter running
  } led_state_e;

endpackage

`default_nettype wire

// File: hdl/mem_req_if.sv
// internal host request bus
// one request moves on every edge with valid high, no back-pressure

`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
  import hbm_host_pkg::*;

  logic     valid;  // request strobe
  host_op_e op;
  addr_t    addr;
  data_t    wdata;  // only meaningful on writes

  modport source (output valid, output op, output addr, output wdata);

  modport sink (input valid, input op, input addr, input wdata);

  // the LED monitor only needs to see traffic go by
  modport monitor (input valid, input op);

endinterface

`default_nettype wire

// File: hdl/reset_debounce.sv
// cpu reset button debounce
// filters the push-button and merges it with the system reset into
// the registered core reset

`timescale 1ns/1ps
`default_nettype none

`include "hbm_host_defs.svh"

module reset_debounce (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cpu_reset_i,
  output logic cpu_rst_o,
  output logic core_rst_n_o
);

  localparam int unsigned CNT_W = $clog2(`HBM_DBNC_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`HBM_DBNC_CYCLES - 1);

  logic [CNT_W-1:0] stable_cnt_q;  // consecutive edges with a new button value
  logic             btn_differs;
  logic             dbnc_hit;

  assign btn_differs = cpu_reset_i ^ cpu_rst_o;
  assign dbnc_hit    = btn_differs && (stable_cnt_q == CNT_LAST);

  // counter restarts on any bounce and again after each toggle,
  // so it never runs past its limit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stable_cnt_q <= '0;
      cpu_rst_o    <= 1'b0;
    end else if (!btn_differs) begin
      stable_cnt_q <= '0;            // bounce back, start over
    end else if (dbnc_hit) begin
      stable_cnt_q <= '0;
      cpu_rst_o    <= cpu_reset_i;   // held long enough
    end else begin
      stable_cnt_q <= stable_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) core_rst_n_o <= 1'b0;
    else          core_rst_n_o <= ~cpu_rst_o;
  end

  // the debounced value may only move right after a full stable run
  a_dbnc_toggle: assert property (@(posedge clk_i)
    $past(rst_n_i) && $changed(cpu_rst_o) |-> $past(dbnc_hit))
    else $error("cpu_rst_o changed without a complete debounce run");

endmodule

`default_nettype wire

// File: hdl/host_req_slice.sv
// host request register slice
// registers the incoming host request onto the internal request bus
// and drops requests while the core is held in reset

`timescale 1ns/1ps
`default_nettype none

module host_req_slice (
  input  logic                clk_i,
  input  logic                core_rst_n_i,
  input  logic                req_valid_i,
  input  hbm_host_pkg::host_op_e req_op_i,
  input  hbm_host_pkg::addr_t req_addr_i,
  input  hbm_host_pkg::data_t req_wdata_i,
  mem_req_if.source           req
);

  import hbm_host_pkg::*;

  // --------------------------------------------------
  // strobe
  // --------------------------------------------------
  // one cycle per accepted request, the sink never stalls so there
  // is nothing to hold
  always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
      req.valid <= 1'b0;           // requests under core reset are lost
    end else begin
      req.valid <= req_valid_i;
    end
  end

  // --------------------------------------------------
  // payload
  // --------------------------------------------------
  // only loaded with a request, keeps the fields quiet on idle cycles
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req.op    <= req_op_i;
      req.addr  <= req_addr_i;
      req.wdata <= req_wdata_i;    // don't care on reads
    end
  end

endmodule

`default_nettype wire

// File: hdl/host_bram.sv
// host block RAM
// word-addressed memory behind the request bus, writes in one cycle
// and returns read data with a one-cycle response strobe

`timescale 1ns/1ps
`default_nettype none

`include "hbm_host_defs.svh"

module host_bram (
  input  logic                clk_i,
  input  logic                rst_n_i,
  mem_req_if.sink             req,
  output logic                rsp_valid_o,
  output hbm_host_pkg::data_t rsp_rdata_o
);

  import hbm_host_pkg::*;

  localparam int unsigned DEPTH = 2 ** `HBM_ADDR_WIDTH;

  data_t mem_q [DEPTH];  // maps onto block RAM
  logic  wr_en;
  logic  rd_en;

  assign wr_en = req.valid && (req.op == OP_WRITE);
  assign rd_en = req.valid && (req.op == OP_READ);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  // contents survive both resets
  always_ff @(posedge clk_i) begin
    if (wr_en) mem_q[req.addr] <= req.wdata;
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) rsp_rdata_o <= mem_q[req.addr];  // sees last cycle's write
  end

  // --------------------------------------------------
  // response strobe
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rsp_valid_o <= 1'b0;
    else          rsp_valid_o <= rd_en;
  end

  // a response always belongs to a read on the previous edge
  a_rsp_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> $past(rd_en))
    else $error("response strobe without a read request");

  a_rsp_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(rsp_valid_o))
    else $error("response strobe is unknown");

endmodule

`default_nettype wire

// File: hdl/led_monitor.sv
// board activity LEDs
// shows the debounced cpu reset and stretches write and read traffic
// on the request bus into pulses long enough to see

`timescale 1ns/1ps
`default_nettype none

`include "hbm_host_defs.svh"

module led_monitor (
  input  logic               clk_i,
  input  logic               core_rst_n_i,
  input  logic               rst_n_i,
  input  logic               cpu_rst_i,
  mem_req_if.monitor         req,
  output hbm_host_pkg::led_t led_o
);

  import hbm_host_pkg::*;

  localparam int unsigned NUM_ACT = 2;
  localparam int unsigned WR_CH   = 0;
  localparam int unsigned RD_CH   = 1;
  localparam int unsigned HOLD_W  = $clog2(`HBM_LED_HOLD + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(`HBM_LED_HOLD);

  led_state_e          act_state_q [NUM_ACT];
  logic [HOLD_W-1:0]   act_cnt_q   [NUM_ACT];  // cycles left to stay lit
  logic [NUM_ACT-1:0]  act_hit;
  logic                led_rst_q;

  assign act_hit[WR_CH] = req.valid && (req.op == OP_WRITE);
  assign act_hit[RD_CH] = req.valid && (req.op == OP_READ);

  // --------------------------------------------------
  // activity hold machines, one per channel
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_ACT; i++) begin
      if (!core_rst_n_i) begin
        act_state_q[i] <= LED_IDLE;
        act_cnt_q[i]   <= '0;
      end else if (act_hit[i]) begin
        act_state_q[i] <= LED_HOLD;       // every request restarts the hold
        act_cnt_q[i]   <= HOLD_LOAD;
      end else if (act_state_q[i] == LED_HOLD) begin
        if (act_cnt_q[i] == HOLD_W'(1)) begin
          act_state_q[i] <= LED_IDLE;
          act_cnt_q[i]   <= '0;
        end else begin
          act_cnt_q[i] <= act_cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // reset LED stays up while the core is held, so only the system
  // reset clears it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) led_rst_q <= 1'b0;
    else          led_rst_q <= cpu_rst_i;
  end

  assign led_o = {act_state_q[RD_CH] == LED_HOLD,
                  act_state_q[WR_CH] == LED_HOLD,
                  led_rst_q};

endmodule

`default_nettype wire

// File: hdl/hbm_host_top.sv
// host memory path top level
// debounced core reset, host request slice, block RAM and activity
// LEDs on one clock

`timescale 1ns/1ps
`default_nettype none

module hbm_host_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cpu_reset_i,    // push-button, active high
  input  logic                   req_valid_i,
  input  hbm_host_pkg::host_op_e req_op_i,
  input  hbm_host_pkg::addr_t    req_addr_i,
  input  hbm_host_pkg::data_t    req_wdata_i,
  output logic                   rsp_valid_o,
  output hbm_host_pkg::data_t    rsp_rdata_o,
  output hbm_host_pkg::led_t     led_o
);

  logic cpu_rst;     // debounced button
  logic core_rst_n;  // system and button reset combined

  mem_req_if req_if ();

  // --------------------------------------------------
  // input side
  // --------------------------------------------------
  reset_debounce u_reset_debounce (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .cpu_reset_i (cpu_reset_i),
    .cpu_rst_o   (cpu_rst    ),
    .core_rst_n_o(core_rst_n )
  );

  host_req_slice u_host_req_slice (
    .clk_i       (clk_i      ),
    .core_rst_n_i(core_rst_n ),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i   ),
    .req_addr_i  (req_addr_i ),
    .req_wdata_i (req_wdata_i),
    .req         (req_if     )
  );

  // --------------------------------------------------
  // memory
  // --------------------------------------------------
  host_bram u_host_bram (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req        (req_if     ),
    .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o)
  );

  // --------------------------------------------------
  // board LEDs
  // --------------------------------------------------
  led_monitor u_led_monitor (
    .clk_i       (clk_i     ),
    .core_rst_n_i(core_rst_n),
    .rst_n_i     (rst_n_i   ),
    .cpu_rst_i   (cpu_rst   ),
    .req         (req_if    ),
    .led_o       (led_o     )
  );

endmodule

`default_nettype wire

// File: tb/tb_hbm_host.sv
// host memory path testbench
// directed tests for reset, single and pipelined accesses, activity
// LEDs and the cpu reset debounce, checked against a memory scoreboard

`timescale 1ns/1ps
`default_nettype none

`include "hbm_host_defs.svh"

module tb_hbm_host;

  import hbm_host_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 5000;
  localparam int unsigned BURST_LEN      = 16;
  localparam int unsigned DEPTH          = 2 ** `HBM_ADDR_WIDTH;

  logic     clk_i;
  logic     rst_n_i;
  logic     cpu_reset_i;
  logic     req_valid_i;
  host_op_e req_op_i;
  addr_t    req_addr_i;
  data_t    req_wdata_i;
  logic     rsp_valid_o;
  data_t    rsp_rdata_o;
  led_t     led_o;

  logic [31:0] lfsr_q = 32'h15ce0c7e;
  data_t       sb_mem [DEPTH];        // expected memory contents
  addr_t       burst_addr [BURST_LEN];
  addr_t       single_addr;
  int unsigned pass_cnt = 0;
  int unsigned fail_cnt = 0;
  int unsigned test_fail_base = 0;   // fail count when the test began
  int unsigned cycle_cnt = 0;

  hbm_host_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  // taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #2;  // inputs settle well after the edge
  endtask

  task automatic drive_req(host_op_e op, addr_t addr, data_t wdata);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
  endtask

  task automatic drive_idle();
    req_valid_i = 1'b0;
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) begin
      fail_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_led(led_t got, led_t exp, led_t mask, string what);
    if ((got & mask) !== (exp & mask)) begin
      fail_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b (mask %b)",
               $time, what, got, exp, mask);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp) begin
      fail_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic end_test(string name);
    if (fail_cnt == test_fail_base) $display("test %s: passed", name);
    else $display("test %s: %0d checks failed", name, fail_cnt - test_fail_base);
    test_fail_base = fail_cnt;
  endtask

  // LED must light within limit cycles, counted from the current cycle
  task automatic wait_led(int unsigned idx, int unsigned limit, string what);
    int unsigned n;
    n = 0;
    while (led_o[idx] !== 1'b1 && n < limit) begin
      tick();
      n++;
    end
    if (led_o[idx] !== 1'b1) begin
      fail_cnt++;
      $display("%s: LED %0d did not light in time", what, idx);
    end else begin
      pass_cnt++;
    end
  endtask

  // --------------------------------------------------
  // access tasks
  // --------------------------------------------------
  task automatic write_word(addr_t addr, data_t data);
    drive_req(OP_WRITE, addr, data);
    sb_mem[addr] = data;
    tick();
    drive_idle();
  endtask

  // response is due exactly two cycles after the read is driven
  task automatic read_expect(addr_t addr);
    drive_req(OP_READ, addr, '0);
    tick();
    drive_idle();
    check_valid(rsp_valid_o, 1'b0, "response too early");
    tick();
    check_valid(rsp_valid_o, 1'b1, "response strobe");
    check_data(rsp_rdata_o, sb_mem[addr], "read data");
    tick();
    check_valid(rsp_valid_o, 1'b0, "response longer than one cycle");
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_reset();
    check_valid(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    check_led(led_o, '0, '1, "led_o after reset");
    end_test("reset state");
  endtask

  task automatic test_single();
    data_t d;
    single_addr = addr_t'(rand_bits(`HBM_ADDR_WIDTH));
    d = data_t'(rand_bits(`HBM_DATA_WIDTH));
    write_word(single_addr, d);
    read_expect(single_addr);
    end_test("single access");
  endtask

  task automatic test_burst();
    data_t d;
    data_t exp_q [$];
    for (int unsigned i = 0; i < BURST_LEN; i++) begin
      burst_addr[i] = addr_t'(rand_bits(`HBM_ADDR_WIDTH));
      d = data_t'(rand_bits(`HBM_DATA_WIDTH));
      drive_req(OP_WRITE, burst_addr[i], d);
      sb_mem[burst_addr[i]] = d;  // last write per address wins
      tick();
    end
    for (int unsigned s = 0; s < BURST_LEN + 2; s++) begin
      if (s < BURST_LEN) begin
        drive_req(OP_READ, burst_addr[s], '0);
        exp_q.push_back(sb_mem[burst_addr[s]]);
      end else begin
        drive_idle();
      end
      if (s >= 2) begin
        check_valid(rsp_valid_o, 1'b1, "burst response strobe");
        check_data(rsp_rdata_o, exp_q.pop_front(), "burst read data");
      end else begin
        check_valid(rsp_valid_o, 1'b0, "burst response too early");
      end
      tick();
    end
    check_valid(rsp_valid_o, 1'b0, "extra burst response");
    end_test("pipelined burst");
  endtask

  task automatic test_leds();
    repeat (`HBM_LED_HOLD + 4) tick();
    check_led(led_o, '0, 3'b110, "activity LEDs before traffic");
    write_word(single_addr, sb_mem[single_addr]);
    wait_led(1, 2, "write LED");
    check_led(led_o, 3'b010, 3'b110, "read LED after a write");
    drive_req(OP_READ, single_addr, '0);
    tick();
    drive_idle();
    wait_led(2, 2, "read LED");
    check_led(led_o, 3'b110, 3'b110, "both activity LEDs lit");
    repeat (`HBM_LED_HOLD - 2) tick();
    check_led(led_o, 3'b100, 3'b100, "read LED near the end of its hold");  // counter still running
    repeat (6) tick();
    check_led(led_o, '0, 3'b110, "activity LEDs after hold");
    end_test("activity LEDs");
  endtask

  task automatic test_debounce();
    cpu_reset_i = 1'b1;
    repeat (5) tick();  // too short to pass the filter
    cpu_reset_i = 1'b0;
    repeat (4) tick();
    check_led(led_o, '0, 3'b001, "reset LED after short pulse");
    read_expect(single_addr);

    cpu_reset_i = 1'b1;
    repeat (40) tick();
    check_led(led_o, 3'b001, 3'b001, "reset LED while held");
    drive_req(OP_READ, single_addr, '0);
    tick();
    drive_idle();
    check_valid(rsp_valid_o, 1'b0, "response under core reset");
    repeat (3) begin
      tick();
      check_valid(rsp_valid_o, 1'b0, "response under core reset");
    end

    cpu_reset_i = 1'b0;
    repeat (40) tick();
    check_led(led_o, '0, 3'b001, "reset LED after release");
    for (int unsigned i = 0; i < 4; i++) read_expect(burst_addr[i]);
    read_expect(single_addr);  // memory kept its contents
    end_test("cpu reset debounce");
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    rst_n_i     = 1'b0;
    cpu_reset_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    tick();
    tick();  // core reset lifts one edge after the system reset

    test_reset();
    test_single();
    test_burst();
    test_leds();
    test_debounce();

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hbm_host.f
+incdir+hdl
hdl/hbm_host_pkg.sv
hdl/mem_req_if.sv
hdl/reset_debounce.sv
hdl/host_req_slice.sv
hdl/host_bram.sv
hdl/led_monitor.sv
hdl/hbm_host_top.sv
tb/tb_hbm_host.sv

// File: run_sim.sh
#!/bin/sh
# build and run the host memory path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f hbm_host.f \
  --top-module tb_hbm_host \
  -o sim_hbm_host

out=$(./obj_dir/sim_hbm_host)
echo "$out"

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
else
  exit 1
fi
